// File: logic/sbr_pkg.sv
`default_nettype none

package sbr_pkg;

	typedef logic [7:0]  sbr_payload_t;
	typedef logic [3:0]  sbr_credit_t;
	typedef logic [1:0]  sbr_wb_adr_t;
	typedef logic [15:0] sbr_wb_dat_t;

	// Idle state machine encoding shared by the agent and fabric side
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		ACTIVE_REQ = 3'd1,
		ACTIVE     = 3'd2,
		IDLE_REQ   = 3'd3
	} sbr_ism_e;

	// ----------------------------------------------------------
	// Link structs

	typedef struct packed {
		logic         np;       // Non-posted class
		logic         eom;
		sbr_payload_t payload;
	} sbr_flit_t;

	typedef struct packed {
		logic         npput;
		logic         pcput;
		logic         eom;
		sbr_payload_t payload;
	} sbr_put_t;

	typedef struct packed {
		logic npcup;
		logic pccup;
	} sbr_cup_t;

	// ----------------------------------------------------------
	// Wishbone classic

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		sbr_wb_adr_t adr;
		sbr_wb_dat_t dat;
	} sbr_wb_req_t;

	typedef struct packed {
		logic        ack;
		sbr_wb_dat_t dat;
	} sbr_wb_rsp_t;

	localparam sbr_wb_adr_t SBR_REG_CTRL   = 2'd0;
	localparam sbr_wb_adr_t SBR_REG_TX     = 2'd1;
	localparam sbr_wb_adr_t SBR_REG_RX     = 2'd2;
	localparam sbr_wb_adr_t SBR_REG_CREDIT = 2'd3;

endpackage

`default_nettype wire

// File: logic/sbr_rpt.sv
`default_nettype none

module sbr_rpt #(
	parameter int PAYLOAD_WIDTH = 8
) (
	input  logic              clk,
	input  logic              reset,

	// Agent side
	input  sbr_pkg::sbr_put_t m_put_agt,
	output sbr_pkg::sbr_cup_t m_cup_agt,
	output sbr_pkg::sbr_put_t t_put_agt,
	input  sbr_pkg::sbr_cup_t t_cup_agt,
	input  sbr_pkg::sbr_ism_e side_ism_agent_agt,
	output sbr_pkg::sbr_ism_e side_ism_fabric_agt,
	input  logic              pok_agt,

	// Router side
	output sbr_pkg::sbr_put_t m_put_rtr,
	input  sbr_pkg::sbr_cup_t m_cup_rtr,
	input  sbr_pkg::sbr_put_t t_put_rtr,
	output sbr_pkg::sbr_cup_t t_cup_rtr,
	output sbr_pkg::sbr_ism_e side_ism_agent_rtr,
	input  sbr_pkg::sbr_ism_e side_ism_fabric_rtr,
	output logic              pok_rtr
);

	logic                  m_np_q, m_pc_q, m_eom_q;
	logic                  t_np_q, t_pc_q, t_eom_q;
	sbr_pkg::sbr_payload_t m_pay_q;
	sbr_pkg::sbr_payload_t t_pay_q;

	if (PAYLOAD_WIDTH != $bits(sbr_pkg::sbr_payload_t)) begin : g_width_check
		$error("sbr_rpt: PAYLOAD_WIDTH does not match sbr_payload_t");
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			m_np_q              <= 1'b0;
			m_pc_q              <= 1'b0;
			m_eom_q             <= 1'b0;
			t_np_q              <= 1'b0;
			t_pc_q              <= 1'b0;
			t_eom_q             <= 1'b0;
			m_cup_agt           <= '0;
			t_cup_rtr           <= '0;
			side_ism_agent_rtr  <= sbr_pkg::IDLE;
			side_ism_fabric_agt <= sbr_pkg::IDLE;
			pok_rtr             <= 1'b0;
		end else begin
			m_np_q              <= m_put_agt.npput;   // Toward router
			m_pc_q              <= m_put_agt.pcput;
			m_eom_q             <= m_put_agt.eom;
			t_np_q              <= t_put_rtr.npput;   // Toward agent
			t_pc_q              <= t_put_rtr.pcput;
			t_eom_q             <= t_put_rtr.eom;
			m_cup_agt           <= m_cup_rtr;
			t_cup_rtr           <= t_cup_agt;
			side_ism_agent_rtr  <= side_ism_agent_agt;
			side_ism_fabric_agt <= side_ism_fabric_rtr;
			pok_rtr             <= pok_agt;
		end
	end

	// Payload in both directions
	always_ff @(posedge clk) begin
		m_pay_q <= m_put_agt.payload;
		t_pay_q <= t_put_rtr.payload;
	end

	assign m_put_rtr = '{npput: m_np_q, pcput: m_pc_q, eom: m_eom_q, payload: m_pay_q};
	assign t_put_agt = '{npput: t_np_q, pcput: t_pc_q, eom: t_eom_q, payload: t_pay_q};

endmodule

`default_nettype wire

// File: logic/sbr_rpt_wrap.sv
`default_nettype none

module sbr_rpt_wrap #(
	parameter int PAYLOAD_WIDTH = 8,
	parameter int NUM_RPT       = 1
) (
	input  logic              clk,
	input  logic              reset,

	// Agent side
	input  sbr_pkg::sbr_put_t m_put_agt,
	output sbr_pkg::sbr_cup_t m_cup_agt,
	output sbr_pkg::sbr_put_t t_put_agt,
	input  sbr_pkg::sbr_cup_t t_cup_agt,
	input  sbr_pkg::sbr_ism_e side_ism_agent_agt,
	output sbr_pkg::sbr_ism_e side_ism_fabric_agt,
	input  logic              pok_agt,

	// Router side
	output sbr_pkg::sbr_put_t m_put_rtr,
	input  sbr_pkg::sbr_cup_t m_cup_rtr,
	input  sbr_pkg::sbr_put_t t_put_rtr,
	output sbr_pkg::sbr_cup_t t_cup_rtr,
	output sbr_pkg::sbr_ism_e side_ism_agent_rtr,
	input  sbr_pkg::sbr_ism_e side_ism_fabric_rtr,
	output logic              pok_rtr
);

	// Index NUM_RPT is the agent end, index 0 the router end
	sbr_pkg::sbr_put_t m_put_loc      [NUM_RPT+1];
	sbr_pkg::sbr_cup_t m_cup_loc      [NUM_RPT+1];
	sbr_pkg::sbr_put_t t_put_loc      [NUM_RPT+1];
	sbr_pkg::sbr_cup_t t_cup_loc      [NUM_RPT+1];
	sbr_pkg::sbr_ism_e ism_agent_loc  [NUM_RPT+1];
	sbr_pkg::sbr_ism_e ism_fabric_loc [NUM_RPT+1];
	logic              pok_loc        [NUM_RPT+1];

	// ----------------------------------------------------------
	// Chain ends

	assign m_put_loc[NUM_RPT]     = m_put_agt;
	assign t_cup_loc[NUM_RPT]     = t_cup_agt;
	assign ism_agent_loc[NUM_RPT] = side_ism_agent_agt;
	assign pok_loc[NUM_RPT]       = pok_agt;
	assign m_cup_agt              = m_cup_loc[NUM_RPT];
	assign t_put_agt              = t_put_loc[NUM_RPT];
	assign side_ism_fabric_agt    = ism_fabric_loc[NUM_RPT];

	assign m_cup_loc[0]      = m_cup_rtr;
	assign t_put_loc[0]      = t_put_rtr;
	assign ism_fabric_loc[0] = side_ism_fabric_rtr;
	assign m_put_rtr         = m_put_loc[0];
	assign t_cup_rtr         = t_cup_loc[0];
	assign side_ism_agent_rtr = ism_agent_loc[0];
	assign pok_rtr           = pok_loc[0];

	for (genvar i = 0; i < NUM_RPT; i++) begin : g_rpt
		sbr_rpt #(
			.PAYLOAD_WIDTH(PAYLOAD_WIDTH)
		) u_rpt (
			.clk                (clk),
			.reset              (reset),
			.m_put_agt          (m_put_loc[i+1]),
			.m_cup_agt          (m_cup_loc[i+1]),
			.t_put_agt          (t_put_loc[i+1]),
			.t_cup_agt          (t_cup_loc[i+1]),
			.side_ism_agent_agt (ism_agent_loc[i+1]),
			.side_ism_fabric_agt(ism_fabric_loc[i+1]),
			.pok_agt            (pok_loc[i+1]),
			.m_put_rtr          (m_put_loc[i]),
			.m_cup_rtr          (m_cup_loc[i]),
			.t_put_rtr          (t_put_loc[i]),
			.t_cup_rtr          (t_cup_loc[i]),
			.side_ism_agent_rtr (ism_agent_loc[i]),
			.side_ism_fabric_rtr(ism_fabric_loc[i]),
			.pok_rtr            (pok_loc[i])
		);
	end

endmodule

`default_nettype wire

// File: logic/sbr_ep_ctrl.sv
`default_nettype none

module sbr_ep_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  sbr_pkg::sbr_wb_req_t wb_req,
	output sbr_pkg::sbr_wb_rsp_t wb_rsp,
	output sbr_pkg::sbr_put_t    m_put,
	input  sbr_pkg::sbr_cup_t    m_cup,
	output sbr_pkg::sbr_cup_t    t_cup,
	output sbr_pkg::sbr_ism_e    side_ism_agent,
	input  sbr_pkg::sbr_ism_e    side_ism_fabric,
	output logic                 pok,
	input  sbr_pkg::sbr_flit_t   rx_flit,
	input  logic                 rx_valid,
	output logic                 rx_pop
);

	sbr_pkg::sbr_ism_e     ism_q, ism_d;
	sbr_pkg::sbr_credit_t  pc_cred, np_cred;
	sbr_pkg::sbr_wb_dat_t  rd_data, rsp_dat;
	sbr_pkg::sbr_payload_t put_pay_q;
	sbr_pkg::sbr_cup_t     pop_cls;
	logic                  link_en, pok_q, ack_q;
	logic                  put_np_q, put_pc_q, put_eom_q;
	logic                  req_new, tx_wr, tx_np, tx_ok, put_go;

	// ----------------------------------------------------------
	// Wishbone decode

	assign req_new = wb_req.cyc && wb_req.stb && !ack_q;  // One action per cycle
	assign tx_wr   = wb_req.we && (wb_req.adr == sbr_pkg::SBR_REG_TX);
	assign tx_np   = wb_req.dat[9];
	assign tx_ok   = (ism_q == sbr_pkg::ACTIVE) &&
	                 (tx_np ? (np_cred != '0) : (pc_cred != '0));
	assign put_go  = req_new && tx_wr && tx_ok;
	assign rx_pop  = req_new && !wb_req.we && (wb_req.adr == sbr_pkg::SBR_REG_RX) && rx_valid;

	always_comb begin
		rd_data = '0;
		if (!wb_req.we) begin
			case (wb_req.adr)
				sbr_pkg::SBR_REG_CTRL:   rd_data[5:0] = {side_ism_fabric, ism_q};
				sbr_pkg::SBR_REG_RX: begin
					rd_data[10] = rx_valid;
					if (rx_valid)
						rd_data[9:0] = rx_flit;
				end
				sbr_pkg::SBR_REG_CREDIT: rd_data[7:0] = {np_cred, pc_cred};
				default: ;
			endcase
		end
	end

	// Agent ISM
	always_comb begin
		ism_d = ism_q;
		case (ism_q)
			sbr_pkg::IDLE:
				if (link_en) ism_d = sbr_pkg::ACTIVE_REQ;
			sbr_pkg::ACTIVE_REQ:
				if (!link_en) ism_d = sbr_pkg::IDLE_REQ;
				else if (side_ism_fabric == sbr_pkg::ACTIVE) ism_d = sbr_pkg::ACTIVE;
			sbr_pkg::ACTIVE:
				if (!link_en) ism_d = sbr_pkg::IDLE_REQ;
			sbr_pkg::IDLE_REQ:
				if (side_ism_fabric == sbr_pkg::IDLE) ism_d = sbr_pkg::IDLE;
			default:
				ism_d = sbr_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q     <= 1'b0;
			link_en   <= 1'b0;
			pok_q     <= 1'b0;
			ism_q     <= sbr_pkg::IDLE;
			pc_cred   <= '0;
			np_cred   <= '0;
			put_np_q  <= 1'b0;
			put_pc_q  <= 1'b0;
			put_eom_q <= 1'b0;
			pop_cls   <= '0;
			t_cup     <= '0;
		end else begin
			ack_q <= req_new && (!tx_wr || tx_ok);  // TX waits for ISM and credit
			if (req_new && wb_req.we && (wb_req.adr == sbr_pkg::SBR_REG_CTRL)) begin
				link_en <= wb_req.dat[0];
				pok_q   <= wb_req.dat[1];
			end
			ism_q <= ism_d;

			// Grants from router minus the put going out now
			pc_cred <= pc_cred + sbr_pkg::sbr_credit_t'(m_cup.pccup)
			                   - sbr_pkg::sbr_credit_t'(put_go && !tx_np);
			np_cred <= np_cred + sbr_pkg::sbr_credit_t'(m_cup.npcup)
			                   - sbr_pkg::sbr_credit_t'(put_go && tx_np);

			put_np_q  <= put_go && tx_np;
			put_pc_q  <= put_go && !tx_np;
			put_eom_q <= put_go && wb_req.dat[8];

			pop_cls.npcup <= rx_pop && rx_flit.np;
			pop_cls.pccup <= rx_pop && !rx_flit.np;
			t_cup         <= pop_cls;  // One cycle after ack
		end
	end

	always_ff @(posedge clk) begin
		if (put_go)
			put_pay_q <= wb_req.dat[7:0];
		if (req_new)
			rsp_dat <= rd_data;
	end

	assign m_put = '{npput: put_np_q, pcput: put_pc_q, eom: put_eom_q, payload: put_pay_q};
	assign wb_rsp = '{ack: ack_q, dat: rsp_dat};
	assign side_ism_agent = ism_q;
	assign pok = pok_q;

endmodule

`default_nettype wire

// File: logic/sbr_rx_buffer.sv
`default_nettype none

module sbr_rx_buffer #(
	parameter int RX_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  sbr_pkg::sbr_put_t  t_put,
	input  logic               pop,
	output sbr_pkg::sbr_flit_t head,
	output logic               valid
);

	localparam int AW = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
	localparam int CW = $clog2(RX_DEPTH + 1);

	sbr_pkg::sbr_flit_t mem [RX_DEPTH];
	sbr_pkg::sbr_flit_t flit_in;
	logic [AW-1:0]      wr_ptr, rd_ptr;
	logic [CW-1:0]      count;
	logic               push, pop_ok;

	assign push    = t_put.npput || t_put.pcput;
	assign flit_in = '{np: t_put.npput, eom: t_put.eom, payload: t_put.payload};
	assign pop_ok  = pop && valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == AW'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(push) - CW'(pop_ok);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= flit_in;
	end

	assign head  = mem[rd_ptr];    // Oldest flit
	assign valid = (count != '0);

endmodule

`default_nettype wire

// File: logic/sbr_agent_top.sv
`default_nettype none

module sbr_agent_top #(
	parameter int PAYLOAD_WIDTH = 8,
	parameter int NUM_RPT       = 1,
	parameter int RX_DEPTH      = 8
) (
	input  logic                 clk,
	input  logic                 reset,
	input  sbr_pkg::sbr_wb_req_t wb_req,
	output sbr_pkg::sbr_wb_rsp_t wb_rsp,
	output sbr_pkg::sbr_put_t    m_put_rtr,
	input  sbr_pkg::sbr_cup_t    m_cup_rtr,
	input  sbr_pkg::sbr_put_t    t_put_rtr,
	output sbr_pkg::sbr_cup_t    t_cup_rtr,
	output sbr_pkg::sbr_ism_e    side_ism_agent_rtr,
	input  sbr_pkg::sbr_ism_e    side_ism_fabric_rtr,
	output logic                 pok_rtr
);

	sbr_pkg::sbr_put_t  m_put_agt, t_put_agt;
	sbr_pkg::sbr_cup_t  m_cup_agt, t_cup_agt;
	sbr_pkg::sbr_ism_e  ism_agent, ism_fabric;
	sbr_pkg::sbr_flit_t rx_head;
	logic               pok_agt, rx_valid, rx_pop;

	sbr_ep_ctrl u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.wb_req         (wb_req),
		.wb_rsp         (wb_rsp),
		.m_put          (m_put_agt),
		.m_cup          (m_cup_agt),
		.t_cup          (t_cup_agt),
		.side_ism_agent (ism_agent),
		.side_ism_fabric(ism_fabric),
		.pok            (pok_agt),
		.rx_flit        (rx_head),
		.rx_valid       (rx_valid),
		.rx_pop         (rx_pop)
	);

	sbr_rx_buffer #(
		.RX_DEPTH(RX_DEPTH)
	) u_rx_buffer (
		.clk  (clk),
		.reset(reset),
		.t_put(t_put_agt),
		.pop  (rx_pop),
		.head (rx_head),
		.valid(rx_valid)
	);

	// Pipeline toward the router
	sbr_rpt_wrap #(
		.PAYLOAD_WIDTH(PAYLOAD_WIDTH),
		.NUM_RPT      (NUM_RPT)
	) u_rpt_wrap (
		.clk                (clk),
		.reset              (reset),
		.m_put_agt          (m_put_agt),
		.m_cup_agt          (m_cup_agt),
		.t_put_agt          (t_put_agt),
		.t_cup_agt          (t_cup_agt),
		.side_ism_agent_agt (ism_agent),
		.side_ism_fabric_agt(ism_fabric),
		.pok_agt            (pok_agt),
		.m_put_rtr          (m_put_rtr),
		.m_cup_rtr          (m_cup_rtr),
		.t_put_rtr          (t_put_rtr),
		.t_cup_rtr          (t_cup_rtr),
		.side_ism_agent_rtr (side_ism_agent_rtr),
		.side_ism_fabric_rtr(side_ism_fabric_rtr),
		.pok_rtr            (pok_rtr)
	);

endmodule

`default_nettype wire

// File: dv/tb_sbr_agent.sv
`default_nettype none

module tb_sbr_agent;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PAYLOAD_WIDTH = 8;
	localparam int NUM_RPT       = 2;
	localparam int RX_DEPTH      = 8;
	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 5;
	localparam int HOLD_CYCLES   = 10;   // Window in which a held TX write must stay unacked
	localparam int MAX_POLLS     = 20;

	// Rough test lengths in cycles
	localparam int LINK_UP_CYCLES   = 100;
	localparam int TRANSMIT_CYCLES  = 100;
	localparam int BACKPRESS_CYCLES = 60;
	localparam int RECEIVE_CYCLES   = 120;
	localparam int LINK_DOWN_CYCLES = 200;
	localparam int CYCLE_LIMIT      = RESET_CYCLES + LINK_UP_CYCLES + TRANSMIT_CYCLES +
	                                  BACKPRESS_CYCLES + RECEIVE_CYCLES + LINK_DOWN_CYCLES + 200;

	logic                 clk;
	logic                 reset;
	sbr_pkg::sbr_wb_req_t wb_req;
	sbr_pkg::sbr_wb_rsp_t wb_rsp;
	sbr_pkg::sbr_put_t    m_put_rtr;
	sbr_pkg::sbr_put_t    t_put_rtr;
	sbr_pkg::sbr_cup_t    m_cup_rtr;
	sbr_pkg::sbr_cup_t    t_cup_rtr;
	sbr_pkg::sbr_ism_e    ism_agent_rtr;
	sbr_pkg::sbr_ism_e    ism_fabric_rtr;
	logic                 pok_rtr;

	// Router model state
	sbr_pkg::sbr_flit_t put_log[$];
	logic               cup_log[$];   // 1 for a non-posted credit
	sbr_pkg::sbr_ism_e  ism_log[$];
	sbr_pkg::sbr_ism_e  ism_last;
	int                 rtr_pc_avail;
	int                 rtr_np_avail;
	int                 exp_pc;
	int                 exp_np;
	int                 cycle_count = 0;

	sbr_agent_top #(
		.PAYLOAD_WIDTH(PAYLOAD_WIDTH),
		.NUM_RPT      (NUM_RPT),
		.RX_DEPTH     (RX_DEPTH)
	) u_dut (
		.clk                (clk),
		.reset              (reset),
		.wb_req             (wb_req),
		.wb_rsp             (wb_rsp),
		.m_put_rtr          (m_put_rtr),
		.m_cup_rtr          (m_cup_rtr),
		.t_put_rtr          (t_put_rtr),
		.t_cup_rtr          (t_cup_rtr),
		.side_ism_agent_rtr (ism_agent_rtr),
		.side_ism_fabric_rtr(ism_fabric_rtr),
		.pok_rtr            (pok_rtr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			fail_run($sformatf("timeout: the run took more than %0d cycles", CYCLE_LIMIT));
	end

	// ------------------------------------------------------------
	// Router model

	always @(negedge clk) begin
		if (reset) begin
			ism_fabric_rtr = sbr_pkg::IDLE;
			ism_last       = sbr_pkg::IDLE;
		end else begin
			if (m_put_rtr.npput && m_put_rtr.pcput)
				fail_run("router saw a put marked both posted and non-posted");
			if (m_put_rtr.npput || m_put_rtr.pcput)
				put_log.push_back('{np: m_put_rtr.npput, eom: m_put_rtr.eom,
				                    payload: m_put_rtr.payload});
			if (t_cup_rtr.npcup && t_cup_rtr.pccup)
				fail_run("router saw a credit return of both classes at once");
			if (t_cup_rtr.npcup || t_cup_rtr.pccup) begin
				cup_log.push_back(t_cup_rtr.npcup);
				if (t_cup_rtr.npcup)
					rtr_np_avail++;
				else
					rtr_pc_avail++;
			end
			if (ism_agent_rtr != ism_last) begin
				ism_log.push_back(ism_agent_rtr);
				ism_last = ism_agent_rtr;
			end
			case (ism_agent_rtr)   // Fabric answers the agent request
				sbr_pkg::ACTIVE_REQ, sbr_pkg::ACTIVE: ism_fabric_rtr = sbr_pkg::ACTIVE;
				default:                              ism_fabric_rtr = sbr_pkg::IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Failure and compare tasks

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_flit(input sbr_pkg::sbr_flit_t got, input sbr_pkg::sbr_flit_t exp,
	                          input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s, expected %b %b %h, got %b %b %h",
			                   $time, what, exp.np, exp.eom, exp.payload,
			                   got.np, got.eom, got.payload));
	endtask

	task automatic check_ism(input sbr_pkg::sbr_ism_e got, input sbr_pkg::sbr_ism_e exp,
	                         input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s, expected %0d, got %0d",
			                   $time, what, exp, got));
	endtask

	task automatic check_credit(input sbr_pkg::sbr_credit_t got,
	                            input sbr_pkg::sbr_credit_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s, expected %0d, got %0d",
			                   $time, what, exp, got));
	endtask

	task automatic check_word(input sbr_pkg::sbr_wb_dat_t got, input sbr_pkg::sbr_wb_dat_t exp,
	                          input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s, expected %h, got %h",
			                   $time, what, exp, got));
	endtask

	// ------------------------------------------------------------
	// Wishbone and link helpers

	task automatic wb_drive(input logic we, input sbr_pkg::sbr_wb_adr_t adr,
	                        input sbr_pkg::sbr_wb_dat_t dat);
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
	endtask

	task automatic wb_wait_ack(output sbr_pkg::sbr_wb_dat_t dat);
		@(negedge clk);
		while (!wb_rsp.ack)
			@(negedge clk);
		dat    = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic wb_write(input sbr_pkg::sbr_wb_adr_t adr, input sbr_pkg::sbr_wb_dat_t dat);
		sbr_pkg::sbr_wb_dat_t unused;
		wb_drive(1'b1, adr, dat);
		wb_wait_ack(unused);
	endtask

	task automatic wb_read(input sbr_pkg::sbr_wb_adr_t adr, output sbr_pkg::sbr_wb_dat_t dat);
		wb_drive(1'b0, adr, 16'h0000);
		wb_wait_ack(dat);
	endtask

	task automatic hold_without_ack(input string what);
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			if (wb_rsp.ack)
				fail_run({what, " was acked although it should be held off"});
		end
	endtask

	task automatic grant_credits(input logic np, input int n);
		repeat (n) begin
			@(negedge clk);
			m_cup_rtr = '{npcup: np, pccup: !np};
		end
		@(negedge clk);
		m_cup_rtr = '0;
		if (np)
			exp_np += n;
		else
			exp_pc += n;
	endtask

	task automatic router_put(input sbr_pkg::sbr_flit_t f);
		if ((f.np ? rtr_np_avail : rtr_pc_avail) <= 0)
			fail_run("router model has no receive credit left for this class");
		@(negedge clk);
		t_put_rtr = '{npput: f.np, pcput: !f.np, eom: f.eom, payload: f.payload};
		if (f.np)
			rtr_np_avail--;
		else
			rtr_pc_avail--;
	endtask

	// Random payload and eom with a class that has credit left
	function automatic sbr_pkg::sbr_flit_t random_flit(input int pc_left, input int np_left);
		logic [31:0]        r;
		sbr_pkg::sbr_flit_t f;
		r         = $urandom;
		f.np      = r[9];
		if (f.np && np_left == 0)
			f.np = 1'b0;
		if (!f.np && pc_left == 0)
			f.np = 1'b1;
		f.eom     = r[8];
		f.payload = r[7:0];
		return f;
	endfunction

	function automatic sbr_pkg::sbr_wb_dat_t tx_word(input sbr_pkg::sbr_flit_t f);
		return {6'b0, f.np, f.eom, f.payload};
	endfunction

	task automatic verify_credit_reg(input string what);
		sbr_pkg::sbr_wb_dat_t d;
		wb_read(sbr_pkg::SBR_REG_CREDIT, d);
		check_credit(d[3:0], sbr_pkg::sbr_credit_t'(exp_pc), {what, ", posted credits"});
		check_credit(d[7:4], sbr_pkg::sbr_credit_t'(exp_np), {what, ", non-posted credits"});
	endtask

	task automatic await_ism(input sbr_pkg::sbr_ism_e exp);
		sbr_pkg::sbr_wb_dat_t d;
		int                   polls;
		polls = 0;
		do begin
			wb_read(sbr_pkg::SBR_REG_CTRL, d);
			polls++;
		end while (d[2:0] != exp && polls < MAX_POLLS);
		check_ism(sbr_pkg::sbr_ism_e'(d[2:0]), exp, "agent ISM in CTRL");
		check_ism(sbr_pkg::sbr_ism_e'(d[5:3]), exp, "fabric ISM in CTRL");
	endtask

	task automatic compare_ism_changes(input sbr_pkg::sbr_ism_e first,
	                                   input sbr_pkg::sbr_ism_e second);
		repeat (NUM_RPT + 1) @(negedge clk);   // Last change still crossing the repeaters
		check_word(16'(ism_log.size()), 16'd2, "number of agent ISM changes");
		check_ism(ism_log[0], first, "first agent ISM change");
		check_ism(ism_log[1], second, "second agent ISM change");
	endtask

	task automatic await_puts(input int n);
		while (put_log.size() < n)
			@(negedge clk);
	endtask

	// ------------------------------------------------------------
	// Tests

	task automatic test_link_up();
		sbr_pkg::sbr_wb_dat_t d;
		wb_read(sbr_pkg::SBR_REG_CTRL, d);
		check_ism(sbr_pkg::sbr_ism_e'(d[2:0]), sbr_pkg::IDLE, "agent ISM after reset");
		check_ism(sbr_pkg::sbr_ism_e'(d[5:3]), sbr_pkg::IDLE, "fabric ISM after reset");
		verify_credit_reg("after reset");
		check_word({15'b0, pok_rtr}, 16'h0000, "pok_rtr after reset");
		ism_log.delete();
		wb_write(sbr_pkg::SBR_REG_CTRL, 16'h0003);   // link_en and pok
		await_ism(sbr_pkg::ACTIVE);
		compare_ism_changes(sbr_pkg::ACTIVE_REQ, sbr_pkg::ACTIVE);
		check_word({15'b0, pok_rtr}, 16'h0001, "pok_rtr after CTRL write");
	endtask

	task automatic test_transmit();
		sbr_pkg::sbr_flit_t sent[$];
		sbr_pkg::sbr_flit_t f;
		int                 base;
		base = put_log.size();
		grant_credits(1'b0, 3);
		grant_credits(1'b1, 3);
		repeat (NUM_RPT + 2) @(negedge clk);
		verify_credit_reg("after grant");
		for (int i = 0; i < 6; i++) begin
			f = random_flit(exp_pc, exp_np);
			wb_write(sbr_pkg::SBR_REG_TX, tx_word(f));
			sent.push_back(f);
			if (f.np)
				exp_np--;
			else
				exp_pc--;
			verify_credit_reg("after TX write");
		end
		await_puts(base + 6);
		foreach (sent[i])
			check_flit(put_log[base + i], sent[i], "flit at m_put_rtr");
	endtask

	task automatic test_back_pressure();
		sbr_pkg::sbr_flit_t   f;
		sbr_pkg::sbr_wb_dat_t d;
		int                   base;
		base = put_log.size();
		f    = random_flit(1, 0);
		verify_credit_reg("before back-pressure");
		wb_drive(1'b1, sbr_pkg::SBR_REG_TX, tx_word(f));
		hold_without_ack("TX write without credit");
		grant_credits(1'b0, 1);
		check_word(16'(put_log.size() - base), 16'd0, "puts sent without credit");
		wb_wait_ack(d);
		exp_pc--;
		await_puts(base + 1);
		check_flit(put_log[base], f, "flit after credit arrived");
		verify_credit_reg("after back-pressure");
	endtask

	task automatic test_receive();
		sbr_pkg::sbr_flit_t   sent[$];
		sbr_pkg::sbr_flit_t   f;
		sbr_pkg::sbr_wb_dat_t d;
		int                   base;
		base = cup_log.size();
		for (int i = 0; i < RX_DEPTH; i++) begin
			f = random_flit(rtr_pc_avail, rtr_np_avail);
			router_put(f);
			sent.push_back(f);
		end
		@(negedge clk);
		t_put_rtr = '0;
		repeat (NUM_RPT + 1) @(negedge clk);
		foreach (sent[i]) begin
			wb_read(sbr_pkg::SBR_REG_RX, d);
			check_word(d & 16'hfc00, 16'h0400, "RX valid and upper bits");
			check_flit('{np: d[9], eom: d[8], payload: d[7:0]}, sent[i], "flit read from RX");
			repeat (NUM_RPT + 2) @(negedge clk);
			check_word(16'(cup_log.size() - base), 16'(i + 1), "t_cup pulses after pop");
			check_word({15'b0, cup_log[base + i]}, {15'b0, sent[i].np}, "t_cup class");
		end
		wb_read(sbr_pkg::SBR_REG_RX, d);
		check_word(d, 16'h0000, "RX read when empty");
		repeat (NUM_RPT + 2) @(negedge clk);
		check_word(16'(cup_log.size() - base), 16'(RX_DEPTH), "t_cup pulses after empty read");
		check_credit(sbr_pkg::sbr_credit_t'(rtr_pc_avail), RX_DEPTH / 2, "router posted credits");
		check_credit(sbr_pkg::sbr_credit_t'(rtr_np_avail), RX_DEPTH / 2, "router np credits");
	endtask

	task automatic test_link_down();
		sbr_pkg::sbr_flit_t f;
		int                 base;
		ism_log.delete();
		wb_write(sbr_pkg::SBR_REG_CTRL, 16'h0002);   // Drop link_en, keep pok
		await_ism(sbr_pkg::IDLE);
		compare_ism_changes(sbr_pkg::IDLE_REQ, sbr_pkg::IDLE);
		grant_credits(1'b0, 1);
		repeat (NUM_RPT + 2) @(negedge clk);
		verify_credit_reg("with link down");
		f    = random_flit(1, 0);
		base = put_log.size();
		wb_drive(1'b1, sbr_pkg::SBR_REG_TX, tx_word(f));
		hold_without_ack("TX write with link down");
		wb_req = '0;   // Master abandons the cycle
		check_word(16'(put_log.size() - base), 16'd0, "puts sent with link down");
		wb_write(sbr_pkg::SBR_REG_CTRL, 16'h0003);
		await_ism(sbr_pkg::ACTIVE);
		wb_write(sbr_pkg::SBR_REG_TX, tx_word(f));
		exp_pc--;
		await_puts(base + 1);
		check_flit(put_log[base], f, "flit after link came back");
		verify_credit_reg("after link-down test");
	endtask

	initial begin
		int seed_ret;
		seed_ret       = $urandom(7);
		reset          = 1'b1;
		wb_req         = '0;
		m_cup_rtr      = '0;
		t_put_rtr      = '0;
		ism_fabric_rtr = sbr_pkg::IDLE;
		rtr_pc_avail   = RX_DEPTH / 2;
		rtr_np_avail   = RX_DEPTH / 2;
		exp_pc         = 0;
		exp_np         = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		test_link_up();
		test_transmit();
		test_back_pressure();
		test_receive();
		test_link_down();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/sbr_pkg.sv
logic/sbr_rpt.sv
logic/sbr_rpt_wrap.sv
logic/sbr_ep_ctrl.sv
logic/sbr_rx_buffer.sv
logic/sbr_agent_top.sv
dv/tb_sbr_agent.sv

// File: Bender.yml
package:
  name: sbr_agent

sources:
  - files:
      - logic/sbr_pkg.sv
      - logic/sbr_rpt.sv
      - logic/sbr_rpt_wrap.sv
      - logic/sbr_ep_ctrl.sv
      - logic/sbr_rx_buffer.sv
      - logic/sbr_agent_top.sv
  - target: test
    files:
      - dv/tb_sbr_agent.sv
